// File: tb.f
hw/zx_pkg.sv
hw/cpu_bus_if.sv
hw/zx_clock_enable.sv
hw/zx_mem_pager.sv
hw/zx_ula_port.sv
hw/zx_input_port.sv
hw/zx_core.sv
tb/zx_core_assertions.sv
tb/tb_zx_core.sv

// File: run.sh
#!/bin/sh
# Build and run the zx_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_zx_core \
	--Mdir obj_dir -o sim_zx_core \
	-f tb.f

./obj_dir/sim_zx_core

// File: tb/tb_zx_core.sv
//======================================
// Testbench for the Spectrum bus-side core
// Directed tests of paging, ULA port, read
// path and CPU clock enables
//======================================
`timescale 1ns/1ns

module tb_zx_core
	import zx_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam logic [31:0] SEED = 32'hacfa_d098;

	// Cycle budget of all tests, doubled as a margin
	localparam int SPEED_CYCLES = 4 * (3 * 16 + 256 + 4);
	localparam int BUS_CYCLES   = 600;
	localparam int TIMEOUT_NS   = 2 * (SPEED_CYCLES + BUS_CYCLES) * CLK_PERIOD;

	// Banks per slot for the four +3 all-RAM configurations
	localparam bank_t SPECIAL_BANKS [4][4] = '{
		'{7'd0, 7'd1, 7'd2, 7'd3},
		'{7'd4, 7'd5, 7'd6, 7'd7},
		'{7'd4, 7'd5, 7'd6, 7'd3},
		'{7'd4, 7'd7, 7'd6, 7'd3}
	};

	logic        clk_sys;
	logic        reset;
	zx_model_t   model;
	cpu_speed_t  speed;
	joy_mode_t   joy_mode;
	joy_t        joystick_0;
	joy_t        joystick_1;
	logic [4:0]  key_data;
	logic [15:0] addr;
	logic [7:0]  dout;
	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        m1;
	logic [7:0]  ram_dout;
	logic [7:0]  cpu_din;
	mem_addr_t   ram_addr;
	logic        ram_we;
	logic        ram_rd;
	logic        page_scr;
	logic [2:0]  border_color;
	logic        ear_out;
	logic        mic_out;
	logic        ce_cpu_p;
	logic        ce_cpu_n;

	zx_core #(.DIV_W(4)) UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model        (model),
		.speed        (speed),
		.joy_mode     (joy_mode),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.key_data     (key_data),
		.addr         (addr),
		.dout         (dout),
		.mreq         (mreq),
		.iorq         (iorq),
		.rd           (rd),
		.wr           (wr),
		.m1           (m1),
		.ram_dout     (ram_dout),
		.cpu_din      (cpu_din),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd),
		.page_scr     (page_scr),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all tests finished");
		abort_run();
	end

	//======================================
	// Failure and compare tasks
	//======================================
	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic check_addr(input string name, input mem_addr_t expected,
		input mem_addr_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected bank %0d offset %h, actual bank %0d offset %h",
				name, expected.bank, expected.offset, actual.bank, actual.offset);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_border(input string name, input logic [2:0] expected,
		input logic [2:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	//======================================
	// Bus tasks
	//======================================
	task automatic apply_reset(input zx_model_t m);
		@(posedge clk_sys);
		model <= m;
		speed <= SPEED_X1;
		reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] data);
		@(posedge clk_sys);
		addr <= a;
		dout <= data;
		iorq <= 1'b1;
		wr   <= 1'b1;
		@(posedge clk_sys);
		iorq <= 1'b0;
		wr   <= 1'b0;
	endtask

	// One memory cycle, checking the RAM address and strobes
	task automatic mem_check(input string name, input logic [15:0] a, input logic write,
		input bank_t exp_bank, input logic exp_we);
		@(posedge clk_sys);
		addr <= a;
		mreq <= 1'b1;
		rd   <= !write;
		wr   <= write;
		@(negedge clk_sys);
		check_addr(name, mem_addr_t'({exp_bank, a[13:0]}), ram_addr);
		check_bit({name, " ram_we"}, exp_we, ram_we);
		check_bit({name, " ram_rd"}, !write, ram_rd);
		@(posedge clk_sys);
		mreq <= 1'b0;
		rd   <= 1'b0;
		wr   <= 1'b0;
	endtask

	task automatic read_check(input string name, input logic [15:0] a, input logic is_mem,
		input logic [7:0] expected);
		@(posedge clk_sys);
		addr <= a;
		mreq <= is_mem;
		iorq <= !is_mem;
		rd   <= 1'b1;
		@(negedge clk_sys);
		check_byte(name, expected, cpu_din);
		@(posedge clk_sys);
		mreq <= 1'b0;
		iorq <= 1'b0;
		rd   <= 1'b0;
	endtask

	// Joystick presses as {bit-11 row, bit-12 row}, active high
	function automatic logic [9:0] joy_presses(input joy_mode_t mode, input joy_t j0,
		input joy_t j1);
		joy_t       both;
		joy_t       src12;
		joy_t       src11;
		logic [4:0] r12;
		logic [4:0] r11;
		both  = j0 | j1;
		src12 = (mode == JOY_SINCLAIR12) ? j0 : both;
		src11 = (mode == JOY_SINCLAIR12) ? j1 : both;
		r12   = '0;
		r11   = '0;
		if (mode == JOY_SINCLAIR1 || mode == JOY_SINCLAIR12) begin
			r12[0] = src12[4];
			r12[1] = src12[3];
			r12[2] = src12[2];
			r12[3] = src12[0];
			r12[4] = src12[1];
		end
		if (mode == JOY_SINCLAIR2 || mode == JOY_SINCLAIR12) begin
			r11[0] = src11[1];
			r11[1] = src11[0];
			r11[2] = src11[2];
			r11[3] = src11[3];
			r11[4] = src11[4];
		end
		if (mode == JOY_CURSOR) begin
			r12[4] = both[2];
			r12[3] = both[3];
			r12[2] = both[0];
			r12[0] = both[4];
			r11[4] = both[1];
		end
		return {r11, r12};
	endfunction

	//======================================
	// Directed tests
	//======================================
	task automatic test_reset_map();
		apply_reset(MODEL_128);
		mem_check("reset rom", 16'h0123, 1'b0, 7'd86, 1'b0);
		mem_check("reset 4000", 16'h4567, 1'b0, 7'd5, 1'b0);
		mem_check("reset 8000", 16'h89AB, 1'b0, 7'd2, 1'b0);
		mem_check("reset c000", 16'hCDEF, 1'b0, 7'd0, 1'b0);
		mem_check("reset rom write", 16'h0010, 1'b1, 7'd86, 1'b0);
		@(negedge clk_sys);
		check_bit("reset page_scr", 1'b0, page_scr);
	endtask

	task automatic test_paging_7ffd();
		apply_reset(MODEL_128);
		// Bank 3, shadow screen, ROM page 7
		io_write(16'h7FFD, 8'h1B);
		mem_check("128 c000", 16'hC100, 1'b0, 7'd3, 1'b0);
		mem_check("128 rom", 16'h0200, 1'b0, 7'd87, 1'b0);
		@(negedge clk_sys);
		check_bit("128 page_scr", 1'b1, page_scr);
		io_write(16'h7FFD, 8'h24);
		mem_check("128 lock write", 16'hC000, 1'b0, 7'd4, 1'b0);
		io_write(16'h7FFD, 8'h1F);
		mem_check("128 locked c000", 16'hC000, 1'b0, 7'd4, 1'b0);
		mem_check("128 locked rom", 16'h0000, 1'b0, 7'd86, 1'b0);

		apply_reset(MODEL_48);
		io_write(16'h7FFD, 8'h17);
		mem_check("48 rom", 16'h1000, 1'b0, 7'd95, 1'b0);
		mem_check("48 c000", 16'hC000, 1'b1, 7'd0, 1'b1);

		// Upper bits {d5, d7, d6} over d2..d0
		apply_reset(MODEL_P1024);
		io_write(16'h7FFD, 8'hE5);
		mem_check("p1024 bank 61", 16'hC005, 1'b0, 7'd61, 1'b0);
		io_write(16'h7FFD, 8'h42);
		mem_check("p1024 bank 10", 16'hC006, 1'b0, 7'd10, 1'b0);
		mem_check("p1024 rom", 16'h0000, 1'b0, 7'd86, 1'b0);
	endtask

	task automatic test_paging_plus3();
		int cfg;
		int slot;
		int page;
		apply_reset(MODEL_PLUS3);
		// Bit 14 low is not 7FFD on +3
		io_write(16'h3FFD, 8'h07);
		mem_check("plus3 3ffd ignored", 16'hC000, 1'b0, 7'd0, 1'b0);
		for (cfg = 0; cfg < 4; cfg++) begin
			io_write(16'h1FFD, {5'b00000, cfg[1:0], 1'b1});
			for (slot = 0; slot < 4; slot++)
				mem_check($sformatf("plus3 special %0d slot %0d", cfg, slot),
					{slot[1:0], 14'h0ABC}, 1'b0, SPECIAL_BANKS[cfg][slot], 1'b0);
			mem_check($sformatf("plus3 special %0d write", cfg), 16'h0000, 1'b1,
				SPECIAL_BANKS[cfg][0], 1'b1);
		end
		for (page = 0; page < 4; page++) begin
			io_write(16'h1FFD, {5'b00000, page[1], 2'b00});
			io_write(16'h7FFD, {3'b000, page[0], 4'b0000});
			mem_check($sformatf("plus3 rom page %0d", 8 + page), 16'h1234, 1'b0,
				7'd88 + bank_t'(page), 1'b0);
		end
		mem_check("plus3 rom write", 16'h0000, 1'b1, 7'd91, 1'b0);
	endtask

	task automatic ula_write_check(input logic [7:0] data);
		logic [2:0] old_border;
		logic       old_ear;
		logic       old_mic;
		@(negedge clk_sys);
		old_border = border_color;
		old_ear    = ear_out;
		old_mic    = mic_out;
		@(posedge clk_sys);
		addr <= 16'h00FE;
		dout <= data;
		iorq <= 1'b1;
		wr   <= 1'b1;
		@(negedge clk_sys);
		check_border("ula border hold", old_border, border_color);
		check_bit("ula ear hold", old_ear, ear_out);
		check_bit("ula mic hold", old_mic, mic_out);
		@(posedge clk_sys);
		iorq <= 1'b0;
		wr   <= 1'b0;
		@(negedge clk_sys);
		check_border("ula border", data[2:0], border_color);
		check_bit("ula ear", data[4], ear_out);
		check_bit("ula mic", data[3], mic_out);
	endtask

	// IORQ with M1 high is an interrupt acknowledge, not a port access
	task automatic int_ack_check();
		logic [2:0] old_border;
		@(negedge clk_sys);
		old_border = border_color;
		@(posedge clk_sys);
		addr <= 16'h00FE;
		dout <= {5'b00000, ~old_border};
		m1   <= 1'b1;
		iorq <= 1'b1;
		wr   <= 1'b1;
		@(posedge clk_sys);
		addr <= 16'h001F;
		wr   <= 1'b0;
		rd   <= 1'b1;
		@(negedge clk_sys);
		check_border("int ack border", old_border, border_color);
		check_byte("int ack read", 8'hFF, cpu_din);
		@(posedge clk_sys);
		m1   <= 1'b0;
		iorq <= 1'b0;
		rd   <= 1'b0;
	endtask

	task automatic test_ula_port();
		apply_reset(MODEL_128);
		ula_write_check(8'h1D);
		ula_write_check(8'h02);
		int_ack_check();
	endtask

	task automatic test_input_port();
		int         m;
		joy_mode_t  mode;
		joy_t       j0;
		joy_t       j1;
		logic [4:0] keys;
		logic [7:0] data;
		logic [9:0] presses;
		logic [7:0] kemp;
		for (m = 0; m < 5; m++) begin
			mode    = joy_mode_t'(m);
			j0      = 6'($urandom());
			j1      = 6'($urandom());
			keys    = 5'($urandom());
			data    = 8'($urandom());
			presses = joy_presses(mode, j0, j1);
			kemp    = (mode == JOY_KEMPSTON) ? {2'b00, j0 | j1} : 8'h00;
			@(posedge clk_sys);
			joy_mode   <= mode;
			joystick_0 <= j0;
			joystick_1 <= j1;
			key_data   <= keys;
			ram_dout   <= data;
			read_check($sformatf("kempston mode %0d", m), 16'h001F, 1'b0, kemp);
			read_check($sformatf("row 12 mode %0d", m), 16'hEFFE, 1'b0,
				{3'b111, keys & ~presses[4:0]});
			read_check($sformatf("row 11 mode %0d", m), 16'hF7FE, 1'b0,
				{3'b111, keys & ~presses[9:5]});
			read_check($sformatf("both rows mode %0d", m), 16'hE7FE, 1'b0,
				{3'b111, keys & ~presses[4:0] & ~presses[9:5]});
			read_check($sformatf("memory read mode %0d", m), 16'h8123, 1'b1, data);
			read_check($sformatf("open port mode %0d", m), 16'h00FF, 1'b0, 8'hFF);
		end
	endtask

	task automatic test_clock_enable();
		int         s;
		int         i;
		int         div;
		int         n_p;
		int         n_n;
		int         last_p;
		cpu_speed_t sp;
		// X2, X4, X8, then back to X1
		for (s = 1; s <= 4; s++) begin
			sp  = cpu_speed_t'(s % 4);
			div = 16 >> (s % 4);
			@(posedge clk_sys);
			speed <= sp;
			@(posedge clk_sys);
			repeat (2 * div) begin
				@(negedge clk_sys);
				check_bit($sformatf("settle ce_p speed %0d", s % 4), 1'b0, ce_cpu_p);
				check_bit($sformatf("settle ce_n speed %0d", s % 4), 1'b0, ce_cpu_n);
			end
			repeat (div) @(posedge clk_sys);
			n_p    = 0;
			n_n    = 0;
			last_p = -1;
			for (i = 0; i < 256; i++) begin
				@(negedge clk_sys);
				if (ce_cpu_p) begin
					n_p++;
					last_p = i;
				end
				if (ce_cpu_n) begin
					n_n++;
					if (last_p >= 0)
						check_count("ce_n half period", div / 2, i - last_p);
				end
			end
			check_count($sformatf("ce_p count div %0d", div), 256 / div, n_p);
			check_count($sformatf("ce_n count div %0d", div), 256 / div, n_n);
		end
	endtask

	//======================================
	// Test sequence
	//======================================
	initial begin
		void'($urandom(SEED));
		reset      = 1'b1;
		model      = MODEL_128;
		speed      = SPEED_X1;
		joy_mode   = JOY_KEMPSTON;
		joystick_0 = '0;
		joystick_1 = '0;
		key_data   = '1;
		addr       = '0;
		dout       = '0;
		mreq       = 1'b0;
		iorq       = 1'b0;
		rd         = 1'b0;
		wr         = 1'b0;
		m1         = 1'b0;
		ram_dout   = '0;
		test_reset_map();
		test_paging_7ffd();
		test_paging_plus3();
		test_ula_port();
		test_input_port();
		test_clock_enable();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: tb/zx_core_assertions.sv
//======================================
// Bound checks on the Spectrum core
// Enable and RAM strobe rules, reset exit
//======================================
`timescale 1ns/1ns

module zx_core_assertions (
	input logic clk_sys,
	input logic reset,
	input logic ce_cpu_p,
	input logic ce_cpu_n,
	input logic ram_we,
	input logic ram_rd
);

	// Positive and negative enables are half a period apart
	enables_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(ce_cpu_p && ce_cpu_n)
	) else $error("ce_cpu_p and ce_cpu_n high in the same cycle");

	strobes_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(ram_we && ram_rd)
	) else $error("ram_we and ram_rd high in the same cycle");

	// First cycle out of reset is quiet
	reset_exit_quiet: assert property (
		@(posedge clk_sys) $fell(reset) |-> (!ce_cpu_p && !ce_cpu_n && !ram_we)
	) else $error("Enables or ram_we high in the first cycle after reset");

endmodule

bind zx_core zx_core_assertions u_assertions (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.ce_cpu_p (ce_cpu_p),
	.ce_cpu_n (ce_cpu_n),
	.ram_we   (ram_we),
	.ram_rd   (ram_rd)
);

// File: hw/zx_core.sv
//======================================
// Spectrum bus-side core
// Clock enables, pager, ULA port and the
// CPU read path
//======================================
`timescale 1ns/1ns

module zx_core
	import zx_pkg::*;
#(
	parameter int DIV_W = 4
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  zx_model_t   model,
	input  cpu_speed_t  speed,
	input  joy_mode_t   joy_mode,
	input  joy_t        joystick_0,
	input  joy_t        joystick_1,
	input  logic [4:0]  key_data,
	input  logic [15:0] addr,
	input  logic [7:0]  dout,
	input  logic        mreq,
	input  logic        iorq,
	input  logic        rd,
	input  logic        wr,
	input  logic        m1,
	input  logic [7:0]  ram_dout,
	output logic [7:0]  cpu_din,
	output mem_addr_t   ram_addr,
	output logic        ram_we,
	output logic        ram_rd,
	output logic        page_scr,
	output logic [2:0]  border_color,
	output logic        ear_out,
	output logic        mic_out,
	output logic        ce_cpu_p,
	output logic        ce_cpu_n
);

	cpu_bus_if bus ();

	assign bus.addr = addr;
	assign bus.dout = dout;
	assign bus.mreq = mreq;
	assign bus.iorq = iorq;
	assign bus.rd   = rd;
	assign bus.wr   = wr;
	assign bus.m1   = m1;

	//======================================
	// Clocks
	//======================================
	zx_clock_enable #(.DIV_W(DIV_W)) u_clock_enable (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.speed    (speed),
		.ce_cpu_p (ce_cpu_p),
		.ce_cpu_n (ce_cpu_n)
	);

	//======================================
	// Memory and ports
	//======================================
	zx_mem_pager #(.ROM_BASE(ROM_BANK_BASE)) u_mem_pager (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model    (model),
		.bus      (bus.listener),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.ram_rd   (ram_rd),
		.page_scr (page_scr)
	);

	zx_ula_port u_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus.listener),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	zx_input_port u_input_port (
		.bus        (bus.listener),
		.joy_mode   (joy_mode),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.key_data   (key_data),
		.ram_dout   (ram_dout),
		.cpu_din    (cpu_din)
	);

endmodule

// File: hw/zx_input_port.sv
//======================================
// CPU read path
// Joystick to keyboard mapping, Kempston
// port and read data selection
//======================================
`timescale 1ns/1ns

module zx_input_port
	import zx_pkg::*;
(
	cpu_bus_if.listener bus,
	input  joy_mode_t   joy_mode,
	input  joy_t        joystick_0,
	input  joy_t        joystick_1,
	input  logic [4:0]  key_data,
	input  logic [7:0]  ram_dout,
	output logic [7:0]  cpu_din
);

	joy_t       joy_or;
	logic [4:0] row_12;
	logic [4:0] row_11;
	logic [4:0] joy_kbd;
	logic [7:0] kempston;
	logic       mem_rd;
	logic       io_rd;

	// Half-row at addr bit 12 low, keys 6 to 0
	function automatic logic [4:0] row_12_map(input joy_t j);
		return {j[JOY_LEFT], j[JOY_RIGHT], j[JOY_DOWN], j[JOY_UP], j[JOY_FIRE]};
	endfunction

	// Half-row at addr bit 11 low, keys 1 to 5
	function automatic logic [4:0] row_11_map(input joy_t j);
		return {j[JOY_FIRE], j[JOY_UP], j[JOY_DOWN], j[JOY_RIGHT], j[JOY_LEFT]};
	endfunction

	assign joy_or = joystick_0 | joystick_1;

	//======================================
	// Joystick key presses
	//======================================
	always_comb begin
		row_12 = '0;
		row_11 = '0;
		unique case (joy_mode)
			JOY_SINCLAIR1:  row_12 = row_12_map(joy_or);
			JOY_SINCLAIR2:  row_11 = row_11_map(joy_or);
			JOY_SINCLAIR12: begin
				row_12 = row_12_map(joystick_0);
				row_11 = row_11_map(joystick_1);
			end
			JOY_CURSOR: begin
				row_12 = {joy_or[JOY_DOWN], joy_or[JOY_UP], joy_or[JOY_RIGHT], 1'b0,
					joy_or[JOY_FIRE]};
				row_11 = {joy_or[JOY_LEFT], 4'b0000};
			end
			default: ;
		endcase
	end

	// Active low, only rows selected by the address
	assign joy_kbd = ({5{bus.addr[12]}} | ~row_12) & ({5{bus.addr[11]}} | ~row_11);

	assign kempston = (joy_mode == JOY_KEMPSTON) ? {2'b00, joy_or} : 8'h00;

	//======================================
	// Read data mux
	//======================================
	assign mem_rd = bus.mreq && bus.rd;
	assign io_rd  = bus.iorq && !bus.m1 && bus.rd;

	always_comb begin
		if (mem_rd)
			cpu_din = ram_dout;
		else if (io_rd && bus.addr[5:0] == PORT_KEMPSTON_LOW)
			cpu_din = kempston;
		else if (io_rd && !bus.addr[0])
			cpu_din = {3'b111, key_data & joy_kbd};
		else
			cpu_din = 8'hFF;
	end

endmodule

// File: hw/zx_ula_port.sv
//======================================
// ULA port FE output latch
// Border colour, ear and mic bits
//======================================
`timescale 1ns/1ns

module zx_ula_port (
	input  logic        clk_sys,
	input  logic        reset,
	cpu_bus_if.listener bus,
	output logic [2:0]  border_color,
	output logic        ear_out,
	output logic        mic_out
);

	logic ula_we;
	logic ula_we_q;

	// Any even port address selects the ULA
	assign ula_we = bus.iorq && !bus.m1 && bus.wr && !bus.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_we_q     <= 1'b0;
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else begin
			ula_we_q <= ula_we;
			if (ula_we && !ula_we_q) begin
				border_color <= bus.dout[2:0];
				ear_out      <= bus.dout[4];
				mic_out      <= bus.dout[3];
			end
		end
	end

endmodule

// File: hw/zx_mem_pager.sv
//======================================
// Memory pager
// 7FFD and 1FFD paging registers, ROM
// page choice and RAM address/strobes
//======================================
`timescale 1ns/1ns

module zx_mem_pager
	import zx_pkg::*;
#(
	parameter bank_t ROM_BASE = ROM_BANK_BASE
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  zx_model_t   model,
	cpu_bus_if.listener bus,
	output mem_addr_t   ram_addr,
	output logic        ram_we,
	output logic        ram_rd,
	output logic        page_scr
);

	zx_model_t  model_q;
	logic [5:0] page_reg;
	logic [2:0] page_reg_plus3;
	logic [2:0] page_hi;
	logic       io_wr;
	logic       io_wr_q;
	logic       wr_edge;
	logic       is_48;
	logic       is_p1024;
	logic       is_plus3;
	logic       page_lock;
	logic       write_7ffd;
	logic       write_1ffd;
	logic       page_special;
	logic [3:0] page_rom;
	logic [1:0] slot;
	bank_t      bank;

	//======================================
	// Port decode
	//======================================
	assign io_wr   = bus.iorq && !bus.m1 && bus.wr;
	assign wr_edge = io_wr && !io_wr_q;

	assign is_48    = (model_q == MODEL_48);
	assign is_p1024 = (model_q == MODEL_P1024);
	assign is_plus3 = (model_q == MODEL_PLUS3);

	// Pentagon 1024 ignores the lock bit
	assign page_lock = is_48 || (page_reg[5] && !is_p1024);

	assign write_7ffd = !bus.addr[15] && !bus.addr[1] &&
		(bus.addr[14] || !is_plus3) && !page_lock;
	assign write_1ffd = is_plus3 && (bus.addr[15:12] == 4'b0001) && !bus.addr[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q        <= model;
			io_wr_q        <= 1'b0;
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_hi        <= '0;
		end else begin
			io_wr_q <= io_wr;
			if (wr_edge) begin
				if (write_7ffd) begin
					page_reg <= bus.dout[5:0];
					// Extra bank bits from data 5, 7, 6
					if (is_p1024)
						page_hi <= {bus.dout[5], bus.dout[7:6]};
				end else if (write_1ffd) begin
					page_reg_plus3 <= bus.dout[2:0];
				end
			end
		end
	end

	//======================================
	// Address map
	//======================================
	assign page_special = page_reg_plus3[0];
	assign slot         = bus.addr[15:14];

	always_comb begin
		unique case (model_q)
			MODEL_48:    page_rom = 4'd15;
			MODEL_PLUS3: page_rom = {2'b10, page_reg_plus3[2], page_reg[4]};
			default:     page_rom = {3'b011, page_reg[4]};
		endcase
	end

	always_comb begin
		if (page_special) begin
			// +3 all-RAM configurations
			unique case (page_reg_plus3[2:1])
				2'd0: bank = {5'd0, slot};
				2'd1: bank = {5'd1, slot};
				2'd2: bank = (slot == 2'd3) ? 7'd3 : {5'd1, slot};
				default: begin
					unique case (slot)
						2'd0:    bank = 7'd4;
						2'd1:    bank = 7'd7;
						2'd2:    bank = 7'd6;
						default: bank = 7'd3;
					endcase
				end
			endcase
		end else begin
			unique case (slot)
				2'd0:    bank = ROM_BASE + bank_t'(page_rom);
				2'd1:    bank = 7'd5;
				2'd2:    bank = 7'd2;
				default: bank = {1'b0, page_hi, page_reg[2:0]};
			endcase
		end
	end

	assign ram_addr = '{bank: bank, offset: bus.addr[13:0]};

	assign ram_rd = bus.mreq && bus.rd;
	// ROM slot is read-only outside special mode
	assign ram_we = bus.mreq && bus.wr && (page_special || slot != 2'd0);

	assign page_scr = page_reg[3];

endmodule

// File: hw/zx_clock_enable.sv
//======================================
// CPU clock enable generator
// Positive and negative enables with a
// turbo-selectable divider
//======================================
`timescale 1ns/1ns

module zx_clock_enable
	import zx_pkg::*;
#(
	parameter int DIV_W = 4
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_speed_t speed,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n
);

	logic [DIV_W-1:0] counter;
	logic [DIV_W-1:0] cnt_next;
	logic [DIV_W-1:0] mask;
	logic [DIV_W-1:0] half;
	cpu_speed_t       speed_q;
	logic [DIV_W+1:0] settle;
	logic             run;

	// Low bits that count within one CPU cycle
	assign mask = {DIV_W{1'b1}} >> speed;
	assign half = (mask >> 1) + 1'b1;

	// Outputs are registered against the next count
	assign cnt_next = counter + 1'b1;

	assign run = (settle == '0) && (speed == speed_q);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter  <= '0;
			speed_q  <= speed;
			settle   <= '0;
			ce_cpu_p <= 1'b0;
			ce_cpu_n <= 1'b0;
		end else begin
			counter <= cnt_next;

			// New speed, hold off for two of its periods
			if (speed != speed_q) begin
				speed_q <= speed;
				settle  <= ({2'b00, {DIV_W{1'b1}} >> speed} + 1'b1) << 1;
			end else if (settle != '0) begin
				settle <= settle - 1'b1;
			end

			ce_cpu_p <= run && ((cnt_next & mask) == '0);
			ce_cpu_n <= run && ((cnt_next & mask) == half);
		end
	end

endmodule

// File: hw/cpu_bus_if.sv
//======================================
// CPU bus as seen by the peripherals
//======================================
`timescale 1ns/1ns

interface cpu_bus_if;

	// Address and write data from the CPU
	logic [15:0] addr;
	logic [7:0]  dout;

	// Strobes, all active high
	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        m1;

	modport listener (
		input addr,
		input dout,
		input mreq,
		input iorq,
		input rd,
		input wr,
		input m1
	);

endinterface

// File: hw/zx_pkg.sv
//======================================
// Spectrum core shared definitions
// Machine models, turbo speeds, joystick
// modes and RAM address layout
//======================================
package zx_pkg;

	//======================================
	// Enumerations
	//======================================
	typedef enum logic [1:0] {
		MODEL_128,
		MODEL_P1024,
		MODEL_48,
		MODEL_PLUS3
	} zx_model_t;

	// Dividers of 16, 8, 4 and 2 system clocks
	typedef enum logic [1:0] {
		SPEED_X1,
		SPEED_X2,
		SPEED_X4,
		SPEED_X8
	} cpu_speed_t;

	typedef enum logic [2:0] {
		JOY_KEMPSTON,
		JOY_SINCLAIR1,
		JOY_SINCLAIR2,
		JOY_SINCLAIR12,
		JOY_CURSOR
	} joy_mode_t;

	//======================================
	// Data types
	//======================================
	// Active high, bit 5 is second fire
	typedef logic [5:0] joy_t;

	typedef logic [6:0] bank_t;

	typedef struct packed {
		bank_t       bank;
		logic [13:0] offset;
	} mem_addr_t;

	// Joystick bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	//======================================
	// Memory map and port decode
	//======================================
	// ROM images start above the RAM banks
	localparam bank_t ROM_BANK_BASE = 7'd80;

	localparam logic [5:0] PORT_KEMPSTON_LOW = 6'h1F;

endpackage
